// File: files.f
+incdir+src
src/arp_pkg.sv
src/arp_frame_rx.sv
src/arp_reply_gen.sv
src/arp_eth_tx.sv
src/arp_responder.sv
verification/tb_clock_gen.sv
verification/arp_responder_tb.sv

// File: src/arp_eth_tx.sv
`default_nettype none

`include "arp_params.svh"

module arp_eth_tx (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     frame_valid,
    output logic                    frame_ready,
    input  wire  [47:0]             eth_dest_mac,
    input  wire  [47:0]             eth_src_mac,
    input  wire  arp_pkg::arp_oper_t arp_oper,
    input  wire  [47:0]             arp_sha,
    input  wire  [31:0]             arp_spa,
    input  wire  [47:0]             arp_tha,
    input  wire  [31:0]             arp_tpa,

    output logic                    m_eth_hdr_valid,
    input  wire                     m_eth_hdr_ready,
    output logic [47:0]             m_eth_dest_mac,
    output logic [47:0]             m_eth_src_mac,
    output logic [15:0]             m_eth_type,
    output logic [7:0]              m_eth_payload_tdata,
    output logic                    m_eth_payload_tvalid,
    input  wire                     m_eth_payload_tready,
    output logic                    m_eth_payload_tlast,
    output logic                    m_eth_payload_tuser,

    output logic                    busy
);

    import arp_pkg::*;

    localparam int PAYLOAD_BYTES = `ARP_PAYLOAD_BYTES;
    localparam logic [15:0] HTYPE = `ARP_HTYPE_ETH;
    localparam logic [15:0] PTYPE = `ARP_PTYPE_IPV4;
    localparam logic [4:0] LAST_PTR = 5'(PAYLOAD_BYTES - 1);

    arp_tx_state_t state_reg, state_next;
    logic [4:0]    ptr_reg, ptr_next;
    logic          store_frame;
    logic          frame_ready_next;
    logic          hdr_valid_next;

    arp_oper_t     oper_reg;
    logic [47:0]   sha_reg;
    logic [31:0]   spa_reg;
    logic [47:0]   tha_reg;
    logic [31:0]   tpa_reg;
    logic [PAYLOAD_BYTES*8-1:0] payload_vec;

    // byte stream into the skid register
    logic [7:0]    int_tdata;
    logic          int_tvalid;
    logic          int_tlast;
    logic          int_tready_reg;
    logic          int_tready_early;

    logic [7:0]    tmp_tdata;
    logic          tmp_tvalid, tmp_tvalid_next;
    logic          tmp_tlast;
    logic          out_tvalid_next;
    logic          load_out_from_int;
    logic          load_out_from_tmp;
    logic          load_tmp;

    assign m_eth_type = `ARP_ETHERTYPE;
    assign m_eth_payload_tuser = 1'b0;

    // whole body in wire order, byte 0 in the top bits
    assign payload_vec = {HTYPE, PTYPE, `ARP_HLEN, `ARP_PLEN,
                          oper_reg, sha_reg, spa_reg, tha_reg, tpa_reg};
    assign int_tdata = payload_vec[(PAYLOAD_BYTES - 1 - int'(ptr_reg)) * 8 +: 8];

    always_comb begin
        state_next = state_reg;
        ptr_next = ptr_reg;
        store_frame = 1'b0;
        frame_ready_next = 1'b0;
        hdr_valid_next = m_eth_hdr_valid && !m_eth_hdr_ready;
        int_tvalid = 1'b0;
        int_tlast = 1'b0;

        case (state_reg)
            TX_IDLE: begin
                ptr_next = '0;
                frame_ready_next = !m_eth_hdr_valid;
                if (frame_valid && frame_ready) begin
                    store_frame = 1'b1;
                    frame_ready_next = 1'b0;
                    hdr_valid_next = 1'b1;
                    state_next = TX_WRITE_PAYLOAD;
                    // byte 0 is constant so it can go out right away
                    if (int_tready_reg) begin
                        int_tvalid = 1'b1;
                        ptr_next = 5'd1;
                    end
                end
            end
            TX_WRITE_PAYLOAD: begin
                if (int_tready_reg) begin
                    int_tvalid = 1'b1;
                    ptr_next = ptr_reg + 5'd1;
                    if (ptr_reg == LAST_PTR) begin
                        int_tlast = 1'b1;
                        ptr_next = '0;
                        frame_ready_next = !m_eth_hdr_valid;
                        state_next = TX_IDLE;
                    end
                end
            end
            default: state_next = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= TX_IDLE;
            ptr_reg <= '0;
            frame_ready <= 1'b0;
            m_eth_hdr_valid <= 1'b0;
            busy <= 1'b0;
        end else begin
            state_reg <= state_next;
            ptr_reg <= ptr_next;
            frame_ready <= frame_ready_next;
            m_eth_hdr_valid <= hdr_valid_next;
            busy <= state_next != TX_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (store_frame) begin
            m_eth_dest_mac <= eth_dest_mac;
            m_eth_src_mac <= eth_src_mac;
            oper_reg <= arp_oper;
            sha_reg <= arp_sha;
            spa_reg <= arp_spa;
            tha_reg <= arp_tha;
            tpa_reg <= arp_tpa;
        end
    end

    // ready toward the FSM stays high unless the spare register would fill
    assign int_tready_early = m_eth_payload_tready
                              || (!tmp_tvalid && (!m_eth_payload_tvalid || !int_tvalid));

    always_comb begin
        out_tvalid_next = m_eth_payload_tvalid;
        tmp_tvalid_next = tmp_tvalid;
        load_out_from_int = 1'b0;
        load_out_from_tmp = 1'b0;
        load_tmp = 1'b0;

        if (int_tready_reg) begin
            if (m_eth_payload_tready || !m_eth_payload_tvalid) begin
                out_tvalid_next = int_tvalid;
                load_out_from_int = 1'b1;
            end else begin
                // output stalled so park the byte
                tmp_tvalid_next = int_tvalid;
                load_tmp = 1'b1;
            end
        end else if (m_eth_payload_tready) begin
            out_tvalid_next = tmp_tvalid;
            tmp_tvalid_next = 1'b0;
            load_out_from_tmp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_eth_payload_tvalid <= 1'b0;
            tmp_tvalid <= 1'b0;
            int_tready_reg <= 1'b0;
        end else begin
            m_eth_payload_tvalid <= out_tvalid_next;
            tmp_tvalid <= tmp_tvalid_next;
            int_tready_reg <= int_tready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_int) begin
            m_eth_payload_tdata <= int_tdata;
            m_eth_payload_tlast <= int_tlast;
        end else if (load_out_from_tmp) begin
            m_eth_payload_tdata <= tmp_tdata;
            m_eth_payload_tlast <= tmp_tlast;
        end
        if (load_tmp) begin
            tmp_tdata <= int_tdata;
            tmp_tlast <= int_tlast;
        end
    end

endmodule

`default_nettype wire

// File: src/arp_frame_rx.sv
`default_nettype none

`include "arp_params.svh"

module arp_frame_rx (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     s_eth_hdr_valid,
    output logic                    s_eth_hdr_ready,
    input  wire  [47:0]             s_eth_dest_mac,
    input  wire  [47:0]             s_eth_src_mac,
    input  wire  [15:0]             s_eth_type,
    input  wire  [7:0]              s_eth_payload_tdata,
    input  wire                     s_eth_payload_tvalid,
    output logic                    s_eth_payload_tready,
    input  wire                     s_eth_payload_tlast,
    input  wire                     s_eth_payload_tuser,

    input  wire                     gen_ready,

    output logic                    rx_frame_valid,
    output arp_pkg::arp_oper_t      rx_oper,
    output logic [47:0]             rx_sha,
    output logic [31:0]             rx_spa,
    output logic [47:0]             rx_tha,
    output logic [31:0]             rx_tpa
);

    import arp_pkg::*;

    localparam logic [15:0] HTYPE = `ARP_HTYPE_ETH;
    localparam logic [15:0] PTYPE = `ARP_PTYPE_IPV4;
    localparam logic [4:0] LAST_PTR = 5'(`ARP_PAYLOAD_BYTES - 1);

    arp_rx_state_t state_reg, state_next;
    logic [4:0]    ptr_reg, ptr_next;
    logic          ok_reg, ok_next;
    logic          frame_valid_next;
    logic          byte_match;
    logic          hdr_accept;
    logic          byte_accept;
    logic [15:0]   oper_reg;

    // mac addresses of the request are not checked
    assign hdr_accept = s_eth_hdr_valid && s_eth_hdr_ready;
    assign byte_accept = s_eth_payload_tvalid && s_eth_payload_tready;
    assign rx_oper = arp_oper_t'(oper_reg);

    // compare the fixed leading bytes against the expected constants
    always_comb begin
        case (ptr_reg)
            5'd0:    byte_match = s_eth_payload_tdata == HTYPE[15:8];
            5'd1:    byte_match = s_eth_payload_tdata == HTYPE[7:0];
            5'd2:    byte_match = s_eth_payload_tdata == PTYPE[15:8];
            5'd3:    byte_match = s_eth_payload_tdata == PTYPE[7:0];
            5'd4:    byte_match = s_eth_payload_tdata == `ARP_HLEN;
            5'd5:    byte_match = s_eth_payload_tdata == `ARP_PLEN;
            default: byte_match = 1'b1;
        endcase
    end

    always_comb begin
        state_next = state_reg;
        ptr_next = ptr_reg;
        ok_next = ok_reg;
        frame_valid_next = 1'b0;

        case (state_reg)
            RX_IDLE: begin
                ptr_next = '0;
                if (hdr_accept) begin
                    // other ethertypes are drained without a pulse
                    ok_next = s_eth_type == `ARP_ETHERTYPE;
                    state_next = ok_next ? RX_READ_PAYLOAD : RX_DRAIN;
                end
            end
            RX_READ_PAYLOAD: begin
                if (byte_accept) begin
                    ptr_next = ptr_reg + 5'd1;
                    ok_next = ok_reg && byte_match;
                    if (s_eth_payload_tlast) begin
                        // a short body ends here and is dropped
                        state_next = RX_IDLE;
                        frame_valid_next = (ptr_reg == LAST_PTR) && ok_next
                                           && !s_eth_payload_tuser;
                    end else if (ptr_reg == LAST_PTR) begin
                        state_next = RX_DRAIN;
                    end
                end
            end
            RX_DRAIN: begin
                // padding or rejected frame up to tlast
                if (byte_accept && s_eth_payload_tlast) begin
                    state_next = RX_IDLE;
                    frame_valid_next = ok_reg && !s_eth_payload_tuser;
                end
            end
            default: state_next = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= RX_IDLE;
            ptr_reg <= '0;
            ok_reg <= 1'b0;
            rx_frame_valid <= 1'b0;
            s_eth_hdr_ready <= 1'b0;
            s_eth_payload_tready <= 1'b0;
        end else begin
            state_reg <= state_next;
            ptr_reg <= ptr_next;
            ok_reg <= ok_next;
            rx_frame_valid <= frame_valid_next;
            // hold off new headers while a pulse is in flight or the generator is full
            s_eth_hdr_ready <= (state_next == RX_IDLE) && gen_ready
                               && !frame_valid_next && !rx_frame_valid;
            s_eth_payload_tready <= state_next != RX_IDLE;
        end
    end

    // shift body bytes into the field registers
    always_ff @(posedge clk) begin
        if (byte_accept && state_reg == RX_READ_PAYLOAD) begin
            case (ptr_reg) inside
                [5'd6:5'd7]:   oper_reg <= {oper_reg[7:0], s_eth_payload_tdata};
                [5'd8:5'd13]:  rx_sha <= {rx_sha[39:0], s_eth_payload_tdata};
                [5'd14:5'd17]: rx_spa <= {rx_spa[23:0], s_eth_payload_tdata};
                [5'd18:5'd23]: rx_tha <= {rx_tha[39:0], s_eth_payload_tdata};
                [5'd24:5'd27]: rx_tpa <= {rx_tpa[23:0], s_eth_payload_tdata};
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/arp_params.svh
`ifndef ARP_PARAMS_SVH
`define ARP_PARAMS_SVH

// ethernet type field of arp frames
`define ARP_ETHERTYPE 16'h0806

// fixed fields of an arp body for ethernet and ipv4
`define ARP_HTYPE_ETH 16'h0001
`define ARP_PTYPE_IPV4 16'h0800
`define ARP_HLEN 8'd6
`define ARP_PLEN 8'd4

// htype through tpa
`define ARP_PAYLOAD_BYTES 28

`endif

// File: src/arp_pkg.sv
`default_nettype none

package arp_pkg;

    // values of the oper field
    typedef enum logic [15:0] {
        ARP_OPER_REQUEST = 16'd1,
        ARP_OPER_REPLY   = 16'd2
    } arp_oper_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_READ_PAYLOAD,
        RX_DRAIN
    } arp_rx_state_t;

    typedef enum logic {
        TX_IDLE,
        TX_WRITE_PAYLOAD
    } arp_tx_state_t;

endpackage

`default_nettype wire

// File: src/arp_reply_gen.sv
`default_nettype none

module arp_reply_gen (
    input  wire                     clk,
    input  wire                     rst,

    input  wire  [47:0]             local_mac,
    input  wire  [31:0]             local_ip,

    input  wire                     rx_frame_valid,
    input  wire  arp_pkg::arp_oper_t rx_oper,
    input  wire  [47:0]             rx_sha,
    input  wire  [31:0]             rx_spa,
    input  wire  [31:0]             rx_tpa,
    output logic                    gen_ready,

    output logic                    frame_valid,
    input  wire                     frame_ready,
    output logic [47:0]             eth_dest_mac,
    output logic [47:0]             eth_src_mac,
    output arp_pkg::arp_oper_t      arp_oper,
    output logic [47:0]             arp_sha,
    output logic [31:0]             arp_spa,
    output logic [47:0]             arp_tha,
    output logic [31:0]             arp_tpa
);

    import arp_pkg::*;

    logic full_reg;
    logic is_match;

    // only requests aimed at our own address get an answer
    assign is_match = rx_frame_valid && (rx_oper == ARP_OPER_REQUEST)
                      && (rx_tpa == local_ip);

    assign gen_ready = !full_reg;
    assign frame_valid = full_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_reg <= 1'b0;
        end else if (is_match) begin
            full_reg <= 1'b1;
        end else if (frame_valid && frame_ready) begin
            full_reg <= 1'b0;
        end
    end

    // one entry holding the reply until the transmitter takes it
    always_ff @(posedge clk) begin
        if (is_match) begin
            eth_dest_mac <= rx_sha;
            eth_src_mac <= local_mac;
            arp_oper <= ARP_OPER_REPLY;
            arp_sha <= local_mac;
            arp_spa <= local_ip;
            // requester becomes the target
            arp_tha <= rx_sha;
            arp_tpa <= rx_spa;
        end
    end

endmodule

`default_nettype wire

// File: src/arp_responder.sv
`default_nettype none

module arp_responder (
    input  wire          clk,
    input  wire          rst,

    input  wire  [47:0]  local_mac,
    input  wire  [31:0]  local_ip,

    input  wire          s_eth_hdr_valid,
    output logic         s_eth_hdr_ready,
    input  wire  [47:0]  s_eth_dest_mac,
    input  wire  [47:0]  s_eth_src_mac,
    input  wire  [15:0]  s_eth_type,
    input  wire  [7:0]   s_eth_payload_tdata,
    input  wire          s_eth_payload_tvalid,
    output logic         s_eth_payload_tready,
    input  wire          s_eth_payload_tlast,
    input  wire          s_eth_payload_tuser,

    output logic         m_eth_hdr_valid,
    input  wire          m_eth_hdr_ready,
    output logic [47:0]  m_eth_dest_mac,
    output logic [47:0]  m_eth_src_mac,
    output logic [15:0]  m_eth_type,
    output logic [7:0]   m_eth_payload_tdata,
    output logic         m_eth_payload_tvalid,
    input  wire          m_eth_payload_tready,
    output logic         m_eth_payload_tlast,
    output logic         m_eth_payload_tuser,

    output logic         busy
);

    import arp_pkg::*;

    // receiver to reply generator
    logic        gen_ready;
    logic        rx_frame_valid;
    arp_oper_t   rx_oper;
    logic [47:0] rx_sha;
    logic [31:0] rx_spa;
    logic [31:0] rx_tpa;

    // reply generator to transmitter
    logic        frame_valid;
    logic        frame_ready;
    logic [47:0] eth_dest_mac;
    logic [47:0] eth_src_mac;
    arp_oper_t   arp_oper;
    logic [47:0] arp_sha;
    logic [31:0] arp_spa;
    logic [47:0] arp_tha;
    logic [31:0] arp_tpa;

    // target mac of a request plays no part in the reply
    arp_frame_rx arp_frame_rx_i (
        .*,
        .rx_tha ()
    );

    arp_reply_gen arp_reply_gen_i (.*);

    arp_eth_tx arp_eth_tx_i (.*);

endmodule

`default_nettype wire

// File: verification/arp_responder_tb.sv
`default_nettype none

module arp_responder_tb;

    // single, no reply, malformed with follow-ups, padding pairs, back-pressure
    localparam int TOTAL_FRAMES = 1 + 2 + 10 + 6 + 20;

    logic         clk;
    logic         rst;
    logic [47:0]  local_mac;
    logic [31:0]  local_ip;
    logic         s_eth_hdr_valid;
    logic         s_eth_hdr_ready;
    logic [47:0]  s_eth_dest_mac;
    logic [47:0]  s_eth_src_mac;
    logic [15:0]  s_eth_type;
    logic [7:0]   s_eth_payload_tdata;
    logic         s_eth_payload_tvalid;
    logic         s_eth_payload_tready;
    logic         s_eth_payload_tlast;
    logic         s_eth_payload_tuser;
    logic         m_eth_hdr_valid;
    logic         m_eth_hdr_ready;
    logic [47:0]  m_eth_dest_mac;
    logic [47:0]  m_eth_src_mac;
    logic [15:0]  m_eth_type;
    logic [7:0]   m_eth_payload_tdata;
    logic         m_eth_payload_tvalid;
    logic         m_eth_payload_tready;
    logic         m_eth_payload_tlast;
    logic         m_eth_payload_tuser;
    logic         busy;

    logic         random_ready;
    logic [31:0]  stim_rng;
    logic [31:0]  ready_rng;
    // expected replies as {header 112 bits, body 224 bits}
    logic [335:0] exp_q[$];
    logic [111:0] hdr_q[$];
    logic [223:0] pay_q[$];
    logic [223:0] cur_payload;
    int           byte_count;
    int           error_count;
    int           tests_run;
    int           tests_failed;
    int           errors_at_start;

    tb_clock_gen #(.PERIOD(8)) tb_clock_gen_i (.clk(clk));

    arp_responder arp_responder_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_rng = xorshift(stim_rng);
        return stim_rng;
    endfunction

    function automatic logic [47:0] random_mac();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = stim_rand();
        lo = stim_rand();
        return {hi[15:0], lo};
    endfunction

    // body in wire order, htype in the top bits
    function automatic logic [223:0] arp_body(input logic [15:0] htype, input logic [7:0] plen,
                                              input logic [15:0] oper, input logic [47:0] sha,
                                              input logic [31:0] spa, input logic [47:0] tha,
                                              input logic [31:0] tpa);
        return {htype, 16'h0800, 8'd6, plen, oper, sha, spa, tha, tpa};
    endfunction

    // reply to a request: back to the sender, our addresses as source
    function automatic logic [335:0] expected_reply(input logic [47:0] req_sha,
                                                    input logic [31:0] req_spa);
        return {req_sha, local_mac, 16'h0806,
                16'h0001, 16'h0800, 8'd6, 8'd4, 16'd2,
                local_mac, local_ip, req_sha, req_spa};
    endfunction

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        error_count++;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_frame(input logic [15:0] etype, input logic [223:0] body,
                              input int len, input logic tuser_last);
        logic [31:0] r;
        s_eth_hdr_valid = 1'b1;
        s_eth_dest_mac = 48'hffff_ffff_ffff;
        s_eth_src_mac = body[159:112];
        s_eth_type = etype;
        while (!s_eth_hdr_ready) @(negedge clk);
        @(negedge clk);
        s_eth_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            if (i < 28) begin
                s_eth_payload_tdata = body[(27 - i) * 8 +: 8];
            end else begin
                r = stim_rand();
                s_eth_payload_tdata = r[7:0];
            end
            s_eth_payload_tvalid = 1'b1;
            s_eth_payload_tlast = i == len - 1;
            s_eth_payload_tuser = tuser_last && (i == len - 1);
            while (!s_eth_payload_tready) @(negedge clk);
            @(negedge clk);
        end
        s_eth_payload_tvalid = 1'b0;
        s_eth_payload_tlast = 1'b0;
        s_eth_payload_tuser = 1'b0;
    endtask

    task automatic send_request(input logic [47:0] sha, input logic [31:0] spa,
                                input logic [31:0] tpa, input int pad);
        if (tpa == local_ip) exp_q.push_back(expected_reply(sha, spa));
        send_frame(16'h0806, arp_body(16'h0001, 8'd4, 16'd1, sha, spa, 48'h0, tpa),
                   28 + pad, 1'b0);
    endtask

    // all expected replies seen and both sides quiet
    task automatic wait_idle();
        do @(posedge clk);
        while (!(exp_q.size() == 0 && s_eth_hdr_ready && !m_eth_hdr_valid
                 && !m_eth_payload_tvalid));
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        if (hdr_q.size() != 0 || pay_q.size() != 0) begin
            report_error("reply header and payload counts differ");
        end
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    task automatic compare_reply();
        logic [335:0] got;
        logic [335:0] want;
        got = {hdr_q.pop_front(), pay_q.pop_front()};
        if (exp_q.size() == 0) begin
            report_error("reply with no matching request");
            return;
        end
        want = exp_q.pop_front();
        if (got[335:224] !== want[335:224]) begin
            report_error($sformatf("header %h, expected %h", got[335:224], want[335:224]));
        end
        for (int i = 0; i < 28; i++) begin
            if (got[(27 - i) * 8 +: 8] !== want[(27 - i) * 8 +: 8]) begin
                report_error($sformatf("payload byte %0d is %h, expected %h", i,
                                       got[(27 - i) * 8 +: 8], want[(27 - i) * 8 +: 8]));
                break;
            end
        end
    endtask

    // output side: ready pattern, capture and compare
    always @(negedge clk) begin
        if (rst) begin
            m_eth_hdr_ready = 1'b0;
            m_eth_payload_tready = 1'b0;
        end else begin
            if (random_ready) begin
                ready_rng = xorshift(ready_rng);
                m_eth_hdr_ready = ready_rng[3];
                m_eth_payload_tready = ready_rng[9] || ready_rng[17];
            end else begin
                m_eth_hdr_ready = 1'b1;
                m_eth_payload_tready = 1'b1;
            end
            if (m_eth_hdr_valid && m_eth_hdr_ready) begin
                hdr_q.push_back({m_eth_dest_mac, m_eth_src_mac, m_eth_type});
            end
            if (m_eth_payload_tvalid && m_eth_payload_tready) begin
                if (m_eth_payload_tuser) report_error("tuser set on output byte");
                cur_payload = {cur_payload[215:0], m_eth_payload_tdata};
                byte_count++;
                if (m_eth_payload_tlast) begin
                    if (byte_count != 28) report_error($sformatf("tlast on byte %0d", byte_count));
                    pay_q.push_back(cur_payload);
                    byte_count = 0;
                end else if (byte_count == 28) begin
                    report_error("byte 28 without tlast");
                end
            end
            if (hdr_q.size() > 0 && pay_q.size() > 0) compare_reply();
        end
    end

    initial begin
        logic [47:0] sha;
        logic [31:0] spa;
        logic [31:0] r;
        rst = 1'b1;
        local_mac = 48'h02_00_5e_10_20_30;
        local_ip = 32'hc0a8_0164;
        s_eth_hdr_valid = 1'b0;
        s_eth_dest_mac = '0;
        s_eth_src_mac = '0;
        s_eth_type = '0;
        s_eth_payload_tdata = '0;
        s_eth_payload_tvalid = 1'b0;
        s_eth_payload_tlast = 1'b0;
        s_eth_payload_tuser = 1'b0;
        m_eth_hdr_ready = 1'b0;
        m_eth_payload_tready = 1'b0;
        random_ready = 1'b0;
        stim_rng = 32'd54;
        ready_rng = 32'd54;
        cur_payload = '0;
        byte_count = 0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        errors_at_start = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        sha = random_mac();
        spa = stim_rand();
        send_request(sha, spa, local_ip, 0);
        wait_idle();
        finish_test("single request");

        // other target ip, then an oper reply aimed at us
        sha = random_mac();
        spa = stim_rand();
        send_request(sha, spa, local_ip ^ 32'h1, 0);
        sha = random_mac();
        spa = stim_rand();
        send_frame(16'h0806, arp_body(16'h0001, 8'd4, 16'd2, sha, spa, local_mac, local_ip),
                   28, 1'b0);
        wait_idle();
        finish_test("no reply");

        // type, htype, plen, short body, tuser; each followed by a good request
        for (int k = 0; k < 5; k++) begin
            sha = random_mac();
            spa = stim_rand();
            send_frame((k == 0) ? 16'h0800 : 16'h0806,
                       arp_body((k == 1) ? 16'h0002 : 16'h0001, (k == 2) ? 8'd6 : 8'd4,
                                16'd1, sha, spa, 48'h0, local_ip),
                       (k == 3) ? 20 : 28, k == 4);
            send_request(sha, spa, local_ip, 0);
        end
        wait_idle();
        finish_test("malformed frames");

        for (int k = 0; k < 3; k++) begin
            sha = random_mac();
            spa = stim_rand();
            r = stim_rand();
            send_request(sha, spa, local_ip, 0);
            send_request(sha, spa, local_ip, 1 + r[3:0]);
        end
        wait_idle();
        finish_test("padding");

        @(posedge clk);
        random_ready = 1'b1;
        @(negedge clk);
        for (int k = 0; k < 20; k++) begin
            sha = random_mac();
            spa = stim_rand();
            r = stim_rand();
            send_request(sha, spa, local_ip, r[2:0]);
        end
        wait_idle();
        if (busy) report_error("busy high with output idle");
        finish_test("back-pressure");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // generous bound per frame sent
    initial begin
        repeat (TOTAL_FRAMES * 200) @(posedge clk);
        $display("watchdog timeout, replies did not finish in time");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire
